// File: coh_config.svh
// Sizing macros for the MESI subsystem; include in any file that needs widths or counts
`ifndef COH_CONFIG_SVH
`define COH_CONFIG_SVH

// Processor count, only two are wired in coh_system
`define COH_CPUS 2

// Direct-mapped L1, index is addr[3:2]
`define COH_LINES 4

// Byte address, tag is addr[7:4]
`define COH_ADDR_W 8

// One word per line
`define COH_DATA_W 32

`define COH_MEM_WORDS 64  // L2 words, 256 bytes total

// Cycles from L2 start to ready strobe, at least 2
`define COH_L2_LATENCY 3

`endif

// File: coh_pkg.sv
// Types shared by the caches, bus controller and testbench; import with coh_pkg::*
package coh_pkg;

    // Line state kept per L1 line
    typedef enum logic [1:0] {
        INVALID   = 2'd0,
        SHARED    = 2'd1,
        EXCLUSIVE = 2'd2,
        MODIFIED  = 2'd3
    } mesi_t;

    // Bus command issued by a requesting cache
    typedef enum logic [1:0] {
        BUS_RD   = 2'd0,  // Read for sharing
        BUS_RDX  = 2'd1,  // Read for ownership
        BUS_UPGR = 2'd2,  // Invalidate others, no data
        BUS_WB   = 2'd3   // Dirty victim to L2
    } bus_op_t;

    // Bus controller transaction steps
    typedef enum logic [2:0] {
        BUS_IDLE, BUS_GRANT, BUS_SNOOP, BUS_XFER, BUS_READ_L2, BUS_WRITE_L2, BUS_DONE
    } bus_state_t;

endpackage

// File: snoop_bus_if.sv
// Link between one L1 cache and the bus controller; one instance per CPU in coh_system
`include "coh_config.svh"
`timescale 1ns/100ps

interface snoop_bus_if import coh_pkg::*; ();
    // Request side
    logic                   req;         // Level, held with op and addr until grant_done
    bus_op_t                op;
    logic [`COH_ADDR_W-1:0] addr;
    logic [`COH_DATA_W-1:0] wb_data;     // Victim word for BUS_WB
    logic                   grant_done;  // One cycle, ends the transaction
    logic [`COH_DATA_W-1:0] load_data;   // Valid with grant_done
    logic                   exclusive;   // BUS_RD found no other copy

    // Snoop side, this cache answers for the other requester
    logic                   snoop_valid; // Held until snoop_done
    bus_op_t                snoop_op;
    logic [`COH_ADDR_W-1:0] snoop_addr;
    logic                   snoop_done;  // Pulse one cycle after snoop_valid seen
    logic                   snoop_hit;
    logic                   snoop_dirty;
    logic [`COH_DATA_W-1:0] snoop_data;

    modport cache (
        output req, op, addr, wb_data,
        output snoop_done, snoop_hit, snoop_dirty, snoop_data,
        input  grant_done, load_data, exclusive,
        input  snoop_valid, snoop_op, snoop_addr
    );

    modport bus (
        input  req, op, addr, wb_data,
        input  snoop_done, snoop_hit, snoop_dirty, snoop_data,
        output grant_done, load_data, exclusive,
        output snoop_valid, snoop_op, snoop_addr
    );
endinterface

// File: l1_dcache.sv
// Direct-mapped L1 data cache with MESI lines, miss FSM and snoop responder; one per CPU
`include "coh_config.svh"
`timescale 1ns/100ps

module l1_dcache import coh_pkg::*; (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   ren,
    input  logic                   wen,
    input  logic [`COH_ADDR_W-1:0] addr,
    input  logic [`COH_DATA_W-1:0] wdata,
    output logic [`COH_DATA_W-1:0] rdata,
    output logic                   busy,
    output mesi_t                  state,
    snoop_bus_if.cache             bus
);
    localparam int IDX_W = $clog2(`COH_LINES);
    localparam int TAG_W = `COH_ADDR_W - IDX_W - 2;

    typedef enum logic {C_IDLE, C_BUS} miss_state_t;

    logic [TAG_W-1:0]       tag_arr  [`COH_LINES];
    logic [`COH_DATA_W-1:0] data_arr [`COH_LINES];
    mesi_t                  mesi_arr [`COH_LINES];

    miss_state_t            fsm;
    bus_op_t                op_r;
    logic [`COH_ADDR_W-1:0] addr_r;    // Bus address, victim or miss line
    logic                   snp_pend;  // Snoop seen last cycle, answer now

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] sidx;
    logic [TAG_W-1:0] stag;
    logic [IDX_W-1:0] fidx;
    logic [TAG_W-1:0] ftag;
    mesi_t            cur;
    mesi_t            scur;
    logic             req_any;
    logic             tag_hit;
    logic             hit_ok;
    logic             wr_hit;
    logic             fill_en;
    logic             upg_lost;

    // Processor lookup
    assign idx     = addr[IDX_W+1:2];
    assign tag     = addr[`COH_ADDR_W-1:IDX_W+2];
    assign cur     = (tag_arr[idx] == tag) ? mesi_arr[idx] : INVALID;
    assign tag_hit = (cur != INVALID);
    assign req_any = ren | wen;
    // Writes need E or M; snoop cycles stall the CPU so both never touch one line
    assign hit_ok  = tag_hit && !snp_pend && (!wen || cur == EXCLUSIVE || cur == MODIFIED);
    assign wr_hit  = (fsm == C_IDLE) && wen && hit_ok;
    assign busy    = req_any && !((fsm == C_IDLE) && hit_ok);
    assign rdata   = data_arr[idx];
    assign state   = wr_hit ? MODIFIED : cur;  // Result state at completion

    // Snoop lookup, answered straight from the arrays
    assign sidx            = bus.snoop_addr[IDX_W+1:2];
    assign stag            = bus.snoop_addr[`COH_ADDR_W-1:IDX_W+2];
    assign scur            = (tag_arr[sidx] == stag) ? mesi_arr[sidx] : INVALID;
    assign bus.snoop_done  = snp_pend;
    assign bus.snoop_hit   = (scur != INVALID) && (bus.snoop_op != BUS_WB);
    assign bus.snoop_dirty = bus.snoop_hit && (scur == MODIFIED);
    assign bus.snoop_data  = data_arr[sidx];

    // Bus request side
    assign fidx        = addr_r[IDX_W+1:2];
    assign ftag        = addr_r[`COH_ADDR_W-1:IDX_W+2];
    assign bus.req     = (fsm == C_BUS);
    assign bus.op      = op_r;
    assign bus.addr    = addr_r;
    assign bus.wb_data = data_arr[fidx];
    assign fill_en     = bus.req && bus.grant_done && (op_r == BUS_RD || op_r == BUS_RDX);
    // S copy taken away by another writer while waiting for the bus
    assign upg_lost    = (tag_arr[fidx] != ftag) || (mesi_arr[fidx] != SHARED);

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            tag_arr[fidx]  <= ftag;
            data_arr[fidx] <= bus.load_data;
        end else if (wr_hit) begin
            data_arr[idx] <= wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            fsm      <= C_IDLE;
            op_r     <= BUS_RD;
            addr_r   <= '0;
            snp_pend <= 1'b0;
            for (int i = 0; i < `COH_LINES; i++) begin
                mesi_arr[i] <= INVALID;
            end
        end else begin
            snp_pend <= bus.snoop_valid && !snp_pend;
            if (snp_pend && bus.snoop_hit) begin
                mesi_arr[sidx] <= (bus.snoop_op == BUS_RD) ? SHARED : INVALID;  // M/E to S, or kill
            end
            case (fsm)
                C_IDLE: begin
                    if (wr_hit) begin
                        mesi_arr[idx] <= MODIFIED;  // Silent E to M
                    end else if (req_any && !hit_ok && !snp_pend) begin
                        fsm    <= C_BUS;
                        addr_r <= addr;
                        if (tag_hit && wen) begin
                            op_r <= BUS_UPGR;                      // Write on S
                        end else if (mesi_arr[idx] == MODIFIED) begin
                            op_r   <= BUS_WB;                      // Dirty victim first
                            addr_r <= {tag_arr[idx], idx, 2'b00};
                        end else begin
                            op_r <= wen ? BUS_RDX : BUS_RD;
                        end
                    end
                end
                C_BUS: begin
                    if (bus.grant_done) begin
                        case (op_r)
                            BUS_WB: begin
                                mesi_arr[fidx] <= INVALID;
                                op_r           <= wen ? BUS_RDX : BUS_RD;  // Now fetch the miss
                                addr_r         <= addr;
                            end
                            BUS_UPGR: begin
                                if (upg_lost) begin
                                    op_r <= BUS_RDX;
                                end else begin
                                    mesi_arr[fidx] <= MODIFIED;
                                    fsm            <= C_IDLE;
                                end
                            end
                            default: begin
                                // Write lands next cycle through the hit path
                                if (op_r == BUS_RDX) mesi_arr[fidx] <= MODIFIED;
                                else mesi_arr[fidx] <= bus.exclusive ? EXCLUSIVE : SHARED;
                                fsm <= C_IDLE;
                            end
                        endcase
                    end
                end
                default: fsm <= C_IDLE;
            endcase
        end
    end

    // Command held steady until the controller finishes it
    a_req_stable: assert property (@(posedge CLK) disable iff (reset)
        bus.req && !bus.grant_done |=> bus.req && $stable(bus.op) && $stable(bus.addr));

    // Supplying a line for BUS_RD leaves no dirty copy here
    a_rd_snoop_clean: assert property (@(posedge CLK) disable iff (reset)
        snp_pend && bus.snoop_hit && bus.snoop_op == BUS_RD
        |=> mesi_arr[$past(sidx)] != MODIFIED);
endmodule

// File: bus_ctrl.sv
// Bus controller that arbitrates two L1 caches, snoops the other cache and routes L2 data; one in coh_system
`include "coh_config.svh"
`timescale 1ns/100ps

module bus_ctrl import coh_pkg::*; (
    input  logic                   CLK,
    input  logic                   reset,
    snoop_bus_if.bus               cache0,
    snoop_bus_if.bus               cache1,
    output logic                   l2_ren,
    output logic                   l2_wen,
    output logic [`COH_ADDR_W-1:0] l2_addr,
    output logic [`COH_DATA_W-1:0] l2_wdata,
    input  logic [`COH_DATA_W-1:0] l2_rdata,
    input  logic                   l2_ready
);
    bus_state_t             state;
    logic                   owner;        // 1 when cache1 holds the bus
    logic                   prio;         // 1 when cache1 wins a tie
    logic                   win;
    logic                   snp_hit_q;
    logic                   snp_dirty_q;  // Data came from the other cache
    logic [`COH_DATA_W-1:0] snp_data_q;

    bus_op_t                req_op;
    logic [`COH_ADDR_W-1:0] req_addr;
    logic [`COH_DATA_W-1:0] req_wb;
    logic                   snp_done;
    logic                   snp_hit;
    logic                   snp_dirty;
    logic [`COH_DATA_W-1:0] snp_data;
    logic [`COH_DATA_W-1:0] load_data;

    assign win = cache1.req && (!cache0.req || prio);

    // Owner's command and the other cache's snoop answer
    assign req_op    = owner ? cache1.op : cache0.op;
    assign req_addr  = owner ? cache1.addr : cache0.addr;
    assign req_wb    = owner ? cache1.wb_data : cache0.wb_data;
    assign snp_done  = owner ? cache0.snoop_done : cache1.snoop_done;
    assign snp_hit   = owner ? cache0.snoop_hit : cache1.snoop_hit;
    assign snp_dirty = owner ? cache0.snoop_dirty : cache1.snoop_dirty;
    assign snp_data  = owner ? cache0.snoop_data : cache1.snoop_data;
    assign load_data = snp_dirty_q ? snp_data_q : l2_rdata;  // Cache to cache beats L2

    assign cache0.grant_done  = (state == BUS_DONE) && !owner;
    assign cache1.grant_done  = (state == BUS_DONE) && owner;
    assign cache0.load_data   = load_data;
    assign cache1.load_data   = load_data;
    assign cache0.exclusive   = (req_op == BUS_RD) && !snp_hit_q;
    assign cache1.exclusive   = (req_op == BUS_RD) && !snp_hit_q;
    assign cache0.snoop_valid = (state == BUS_SNOOP) && owner;
    assign cache1.snoop_valid = (state == BUS_SNOOP) && !owner;
    assign cache0.snoop_op    = req_op;
    assign cache1.snoop_op    = req_op;
    assign cache0.snoop_addr  = req_addr;
    assign cache1.snoop_addr  = req_addr;

    // XFER writes the dirty snooped word back while the requester takes it
    assign l2_ren   = (state == BUS_READ_L2);
    assign l2_wen   = (state == BUS_XFER) || (state == BUS_WRITE_L2);
    assign l2_addr  = req_addr;
    assign l2_wdata = (state == BUS_XFER) ? snp_data_q : req_wb;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state       <= BUS_IDLE;
            owner       <= 1'b0;
            prio        <= 1'b0;
            snp_hit_q   <= 1'b0;
            snp_dirty_q <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (cache0.req || cache1.req) begin
                        owner <= win;
                        prio  <= !win;  // Loser goes first next time
                        state <= BUS_GRANT;
                    end
                end
                BUS_GRANT: state <= BUS_SNOOP;
                BUS_SNOOP: begin
                    if (snp_done) begin
                        snp_hit_q   <= snp_hit;
                        snp_dirty_q <= snp_dirty;
                        if (req_op == BUS_WB) state <= BUS_WRITE_L2;
                        else if (snp_dirty) state <= BUS_XFER;      // Keep dirty data even on UPGR
                        else if (req_op == BUS_UPGR) state <= BUS_DONE;
                        else state <= BUS_READ_L2;
                    end
                end
                BUS_XFER, BUS_READ_L2, BUS_WRITE_L2: begin
                    if (l2_ready) state <= BUS_DONE;
                end
                BUS_DONE: state <= BUS_IDLE;
                default:  state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == BUS_SNOOP && snp_done) snp_data_q <= snp_data;
    end

    // Grant only ends a request that the cache still holds
    a_grant_req0: assert property (@(posedge CLK) disable iff (reset)
        cache0.grant_done |-> cache0.req);
    a_grant_req1: assert property (@(posedge CLK) disable iff (reset)
        cache1.grant_done |-> cache1.req);

    // Dirty answer from a cache must come with a hit
    a_dirty_hit0: assert property (@(posedge CLK) disable iff (reset)
        cache0.snoop_done && cache0.snoop_dirty |-> cache0.snoop_hit);
    a_dirty_hit1: assert property (@(posedge CLK) disable iff (reset)
        cache1.snoop_done && cache1.snoop_dirty |-> cache1.snoop_hit);
endmodule

// File: l2_mem.sv
// L2 backing store with fixed latency, swept to zero after reset; driven by bus_ctrl
`include "coh_config.svh"
`timescale 1ns/100ps

module l2_mem (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   ren,
    input  logic                   wen,
    input  logic [`COH_ADDR_W-1:0] addr,
    input  logic [`COH_DATA_W-1:0] wdata,
    output logic [`COH_DATA_W-1:0] rdata,
    output logic                   ready
);
    localparam int WIDX_W = $clog2(`COH_MEM_WORDS);
    localparam int LAT_W  = $clog2(`COH_L2_LATENCY + 1);

    logic [`COH_DATA_W-1:0] mem [`COH_MEM_WORDS];
    logic                   sweeping;   // Clearing one word per cycle
    logic [WIDX_W-1:0]      sweep_idx;
    logic                   active;     // Access in flight
    logic [LAT_W-1:0]       lat_cnt;
    logic                   finish;
    logic [WIDX_W-1:0]      widx;

    assign widx   = addr[WIDX_W+1:2];  // Word address
    assign finish = active && (lat_cnt == LAT_W'(1));

    always_ff @(posedge CLK) begin
        if (reset) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
            active    <= 1'b0;
            lat_cnt   <= '0;
            ready     <= 1'b0;
        end else begin
            ready <= finish;
            if (sweeping) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == WIDX_W'(`COH_MEM_WORDS - 1)) sweeping <= 1'b0;
            end else if (active) begin
                lat_cnt <= lat_cnt - 1'b1;
                if (finish) active <= 1'b0;
            end else if ((ren || wen) && !ready) begin  // Skip the request just answered
                active  <= 1'b1;
                lat_cnt <= LAT_W'(`COH_L2_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (sweeping) mem[sweep_idx] <= '0;
        else if (finish && wen) mem[widx] <= wdata;
        if (finish && ren) rdata <= mem[widx];  // Held until the next read
    end
endmodule

// File: coh_system.sv
// Two-CPU MESI subsystem top: two L1 caches, bus controller and L2 with per-CPU ports
`include "coh_config.svh"
`timescale 1ns/100ps

module coh_system import coh_pkg::*; (
    input  logic                                    CLK,
    input  logic                                    reset,
    input  logic [`COH_CPUS-1:0]                    cpu_ren,
    input  logic [`COH_CPUS-1:0]                    cpu_wen,
    input  logic [`COH_CPUS-1:0][`COH_ADDR_W-1:0]   cpu_addr,
    input  logic [`COH_CPUS-1:0][`COH_DATA_W-1:0]   cpu_wdata,
    output logic [`COH_CPUS-1:0][`COH_DATA_W-1:0]   cpu_rdata,
    output logic [`COH_CPUS-1:0]                    cpu_busy,
    output mesi_t [`COH_CPUS-1:0]                   cpu_state
);
    logic                   l2_ren;
    logic                   l2_wen;
    logic                   l2_ready;
    logic [`COH_ADDR_W-1:0] l2_addr;
    logic [`COH_DATA_W-1:0] l2_wdata;
    logic [`COH_DATA_W-1:0] l2_rdata;

    snoop_bus_if bus0 ();  // CPU0 cache link
    snoop_bus_if bus1 ();  // CPU1 cache link

    l1_dcache u_cache0 (
        .CLK(CLK), .reset(reset),
        .ren(cpu_ren[0]), .wen(cpu_wen[0]), .addr(cpu_addr[0]), .wdata(cpu_wdata[0]),
        .rdata(cpu_rdata[0]), .busy(cpu_busy[0]), .state(cpu_state[0]),
        .bus(bus0.cache)
    );

    l1_dcache u_cache1 (
        .CLK(CLK), .reset(reset),
        .ren(cpu_ren[1]), .wen(cpu_wen[1]), .addr(cpu_addr[1]), .wdata(cpu_wdata[1]),
        .rdata(cpu_rdata[1]), .busy(cpu_busy[1]), .state(cpu_state[1]),
        .bus(bus1.cache)
    );

    bus_ctrl u_bus_ctrl (
        .CLK(CLK), .reset(reset),
        .cache0(bus0.bus), .cache1(bus1.bus),
        .l2_ren(l2_ren), .l2_wen(l2_wen), .l2_addr(l2_addr), .l2_wdata(l2_wdata),
        .l2_rdata(l2_rdata), .l2_ready(l2_ready)
    );

    l2_mem u_l2 (
        .CLK(CLK), .reset(reset),
        .ren(l2_ren), .wen(l2_wen), .addr(l2_addr), .wdata(l2_wdata),
        .rdata(l2_rdata), .ready(l2_ready)
    );
endmodule

// File: tb_coh_system.sv
// Testbench for coh_system; replays the accesses in coh_tests.txt and checks data and MESI state
`include "coh_config.svh"
`timescale 1ns/100ps

module tb_coh_system import coh_pkg::*; ();
    localparam int CLK_PERIOD = 40;
    localparam int SAMPLE_DLY = CLK_PERIOD / 4;  // Outputs settled this long after the falling edge

    logic                                  CLK;
    logic                                  reset;
    logic [`COH_CPUS-1:0]                  cpu_ren;
    logic [`COH_CPUS-1:0]                  cpu_wen;
    logic [`COH_CPUS-1:0][`COH_ADDR_W-1:0] cpu_addr;
    logic [`COH_CPUS-1:0][`COH_DATA_W-1:0] cpu_wdata;
    logic [`COH_CPUS-1:0][`COH_DATA_W-1:0] cpu_rdata;
    logic [`COH_CPUS-1:0]                  cpu_busy;
    mesi_t [`COH_CPUS-1:0]                 cpu_state;

    // One entry per access line
    int                     q_cpu[$];
    bit                     q_write[$];
    bit                     q_pair[$];    // Launched with the next entry
    logic [`COH_ADDR_W-1:0] q_addr[$];
    logic [`COH_DATA_W-1:0] q_wdata[$];
    logic [`COH_DATA_W-1:0] q_rdata[$];
    mesi_t                  q_state[$];

    int checks      = 0;
    int errors      = 0;  // Wrong values
    int other_fails = 0;  // Test file problems
    bit loaded      = 1'b0;
    int i;

    coh_system DUT (
        .CLK(CLK), .reset(reset),
        .cpu_ren(cpu_ren), .cpu_wen(cpu_wen), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_rdata(cpu_rdata), .cpu_busy(cpu_busy), .cpu_state(cpu_state)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic mesi_t mesi_from_char(input byte c);
        case (c)
            "M":     return MODIFIED;
            "E":     return EXCLUSIVE;
            "S":     return SHARED;
            default: return INVALID;
        endcase
    endfunction

    task automatic load_tests();
        int                     fd;
        int                     n;
        int                     cpu;
        byte                    op;
        byte                    st;
        logic [`COH_ADDR_W-1:0] addr;
        logic [`COH_DATA_W-1:0] wdata;
        logic [`COH_DATA_W-1:0] rdata;
        string                  line;
        fd = $fopen("coh_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open coh_tests.txt");
            other_fails++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin  // Skip comments, blanks
                    n = $sscanf(line, "%d %c %h %h %h %c", cpu, op, addr, wdata, rdata, st);
                    if (n != 6 || !(op inside {"R", "W", "r", "w"})) begin
                        $display("Malformed line in coh_tests.txt: %s", line);
                        other_fails++;
                    end else begin
                        q_cpu.push_back(cpu);
                        q_write.push_back(op == "W" || op == "w");
                        q_pair.push_back(op == "r" || op == "w");
                        q_addr.push_back(addr);
                        q_wdata.push_back(wdata);
                        q_rdata.push_back(rdata);
                        q_state.push_back(mesi_from_char(st));
                    end
                end
            end
            $fclose(fd);
            if (q_cpu.size() == 0) begin
                $display("coh_tests.txt holds no accesses");
                other_fails++;
            end
        end
    endtask

    // Present one access, wait for busy low before a rising edge, check, then drop the request
    task automatic run_access(input int t);
        int c;
        c = q_cpu[t];
        @(negedge CLK);
        cpu_addr[c]  = q_addr[t];
        cpu_wdata[c] = q_wdata[t];
        cpu_ren[c]   = !q_write[t];
        cpu_wen[c]   = q_write[t];
        #(SAMPLE_DLY);
        while (cpu_busy[c]) begin
            @(negedge CLK);
            #(SAMPLE_DLY);
        end
        if (!q_write[t]) check_value($sformatf("cpu_rdata[%0d]", c), q_rdata[t], cpu_rdata[c]);
        check_value($sformatf("cpu_state[%0d]", c), 32'(q_state[t]), 32'(cpu_state[c]));
        @(negedge CLK);  // Completing rising edge has passed
        cpu_ren[c] = 1'b0;
        cpu_wen[c] = 1'b0;
    endtask

    initial begin
        cpu_ren   = '0;
        cpu_wen   = '0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        reset     = 1'b1;
        load_tests();
        loaded = 1'b1;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        #(SAMPLE_DLY);
        check_value("cpu_busy", 32'd0, 32'(cpu_busy));  // Idle after reset
        i = 0;
        while (i < q_cpu.size()) begin
            if (q_pair[i] && i + 1 < q_cpu.size()) begin
                fork  // Both CPUs contend for the bus
                    run_access(i);
                    run_access(i + 1);
                join
                i += 2;
            end else begin
                run_access(i);
                i++;
            end
        end
        $display("Checks: %0d, value errors: %0d, other failures: %0d",
                 checks, errors, other_fails);
        if (errors == 0 && other_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, 100 cycles per access plus one spare slot for reset and the L2 sweep
    initial begin
        wait (loaded);
        #((q_cpu.size() + 1) * 100 * CLK_PERIOD);
        $display("Run timed out with an access still waiting on busy");
        $display("TEST FAILED");
        $finish;
    end
endmodule

// File: sources.f
+incdir+.
coh_pkg.sv
snoop_bus_if.sv
l1_dcache.sv
bus_ctrl.sv
l2_mem.sv
coh_system.sv
tb_coh_system.sv

// File: Makefile
# Verilator build and run of the MESI subsystem testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_coh_system, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_coh_system -Mdir obj_dir -f sources.f
	./obj_dir/Vtb_coh_system | tee sim.log
	@grep -q "TEST PASSED" sim.log && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: coh_tests.txt
# cpu op addr wdata expected_rdata expected_state (hex fields, state one of I S E M)
# op R or W; lower case r or w starts together with the next line, which is the other CPU
# Exclusive read miss, then silent E to M
0 R 10 00000000 00000000 E
0 W 10 a5a50001 00000000 M
# Dirty cache-to-cache supply, CPU0 drops M to S
1 R 10 00000000 a5a50001 S
0 R 10 00000000 a5a50001 S
# Upgrade from S invalidates the other copy
1 W 10 b6b60002 00000000 M
0 R 10 00000000 b6b60002 S
1 R 10 00000000 b6b60002 S
# Write miss while the other cache holds the line modified
1 W 34 c7c70003 00000000 M
0 W 34 d8d80004 00000000 M
1 R 34 00000000 d8d80004 S
# Conflict on index 2 evicts a modified line through writeback
0 W 48 e9e90005 00000000 M
0 R 88 00000000 00000000 E
0 R 48 00000000 e9e90005 E
0 W 48 f0f0000a 00000000 M
# Both CPUs waiting on the bus at once
0 w 5c 11110006 00000000 M
1 W 64 22220007 00000000 M
0 r 64 00000000 22220007 S
1 R 5c 00000000 11110006 S
0 w 5c 33330008 00000000 M
1 W 64 44440009 00000000 M
0 R 64 00000000 44440009 S
1 R 5c 00000000 33330008 S
